/* design/meminit_pkg.sv */
/*
 * Shared types and constants for the memory maintenance block.
 * Imported by every RTL module in the design, and by the testbench
 * wherever it needs the same widths or the start-up phase encoding.
 */
`default_nettype none

package meminit_pkg;

    // data words, loader words and both checksums
    typedef logic [31:0] word_t;

    // byte address on the memory port and the processor bus
    typedef logic [31:0] addr_t;

    // byte lane enables, bit n enables byte n of the word
    typedef logic [3:0] ctrl_t;

    // start-up phases, in the order the sequencer walks them
    typedef enum logic [2:0] {
        PH_CALIB  = 3'd0,   // waiting for controller calibration
        PH_ZERO   = 3'd1,   // zero-fill of the zero region
        PH_LOAD   = 3'd2,   // boot image copy from the loader
        PH_VERIFY = 3'd3,   // read-back and checksum compare
        PH_RUN    = 3'd4    // processor bus owns the memory
    } phase_t;

    // processor addresses are cut down to 64 MiB
    localparam addr_t ADDR_MASK = 32'h03ff_ffff;

    // address step per word
    localparam addr_t WORD_BYTES = 32'd4;

    // every start-up access writes or reads a full word
    localparam ctrl_t CTRL_FULL = 4'b1111;

endpackage

`default_nettype wire

/* design/init_sequencer.sv */
/*
 * Start-up phase register. Steps through calibration, zero-fill, image load
 * and read-back, then stays in run until the next reset.
 */
`timescale 1ns/1ps
`default_nettype none

module init_sequencer (
    input  wire                 clk,
    input  wire                 i_rst,
    input  wire                 i_calib_done,
    input  wire                 i_zero_done,
    input  wire                 i_load_done,
    input  wire                 i_verify_done,
    output meminit_pkg::phase_t o_phase,
    output wire                 o_init_done
);
    import meminit_pkg::*;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_phase <= PH_CALIB;
        end else begin
            case (o_phase)
                PH_CALIB:  if (i_calib_done)  o_phase <= PH_ZERO;
                PH_ZERO:   if (i_zero_done)   o_phase <= PH_LOAD;
                PH_LOAD:   if (i_load_done)   o_phase <= PH_VERIFY;
                PH_VERIFY: if (i_verify_done) o_phase <= PH_RUN;
                PH_RUN:    o_phase <= PH_RUN;  // final until reset
                default:   o_phase <= PH_CALIB;
            endcase
        end
    end

    assign o_init_done = (o_phase == PH_RUN);

    // phases only ever move forward between resets
    a_phase_forward: assert property (
        @(posedge clk) disable iff (i_rst)
        o_phase >= $past(o_phase)
    ) else $error("start-up phase moved backward");

endmodule

`default_nettype wire

/* design/zero_fill.sv */
/*
 * Zero-fill engine. Once the sequencer enters the zero phase it issues one
 * full-word write per memory operation from address 0 up to ZERO_BYTES.
 * The write data itself is zero and is supplied by the port mux.
 */
`timescale 1ns/1ps
`default_nettype none

module zero_fill #(
    parameter int unsigned ZERO_BYTES = 64
) (
    input  wire                 clk,
    input  wire                 i_rst,
    input  wire meminit_pkg::phase_t i_phase,
    input  wire                 i_mem_busy,
    output logic                o_wr_en,
    output meminit_pkg::addr_t  o_addr,
    output logic                o_done
);
    import meminit_pkg::*;

    localparam addr_t ZERO_END = addr_t'(ZERO_BYTES);

    logic active;

    assign active = (i_phase == PH_ZERO) && !o_done;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wr_en <= 1'b0;
            o_addr  <= '0;
            o_done  <= 1'b0;
        end else begin
            if (active) begin
                if (o_wr_en) begin
                    // controller took the write
                    if (i_mem_busy) begin
                        o_wr_en <= 1'b0;
                        o_addr  <= o_addr + WORD_BYTES;
                    end
                end else if (!i_mem_busy && (o_addr < ZERO_END)) begin
                    o_wr_en <= 1'b1;  // next word
                end
            end
            if (o_addr >= ZERO_END) begin
                o_done <= 1'b1;  // one cycle after the last step
            end
        end
    end

endmodule

`default_nettype wire

/* design/image_loader.sv */
/*
 * Boot image copy. Takes one word per loader strobe, adds it to the running
 * checksum and writes it to memory from address 0 upward. o_ld_ready tells
 * the word source when the next strobe may be given.
 */
`timescale 1ns/1ps
`default_nettype none

module image_loader #(
    parameter int unsigned IMAGE_BYTES = 32
) (
    input  wire                 clk,
    input  wire                 i_rst,
    input  wire meminit_pkg::phase_t i_phase,
    input  wire                 i_mem_busy,
    input  wire                 i_ld_we,
    input  wire meminit_pkg::word_t i_ld_data,
    output wire                 o_ld_ready,
    output logic                o_wr_en,
    output meminit_pkg::addr_t  o_addr,
    output meminit_pkg::word_t  o_wdata,
    output meminit_pkg::word_t  o_checksum,
    output logic                o_done
);
    import meminit_pkg::*;

    localparam addr_t IMAGE_END = addr_t'(IMAGE_BYTES);

    typedef enum logic [1:0] {
        LD_IDLE,      // waiting for a loader word
        LD_WAIT_BUSY, // write requested, controller not yet busy
        LD_WAIT_REL   // write in progress
    } ld_state_t;

    ld_state_t state;

    // idle, not finished, memory free
    assign o_ld_ready = (i_phase == PH_LOAD) && (state == LD_IDLE) &&
                        !i_mem_busy && (o_addr < IMAGE_END);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state      <= LD_IDLE;
            o_wr_en    <= 1'b0;
            o_addr     <= '0;
            o_checksum <= '0;
            o_done     <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (i_ld_we && o_ld_ready) begin
                        o_wr_en    <= 1'b1;
                        o_checksum <= o_checksum + i_ld_data;
                        state      <= LD_WAIT_BUSY;
                    end
                end
                LD_WAIT_BUSY: begin
                    if (i_mem_busy) begin
                        o_wr_en <= 1'b0;
                        o_addr  <= o_addr + WORD_BYTES;
                        state   <= LD_WAIT_REL;
                    end
                end
                LD_WAIT_REL: begin
                    if (!i_mem_busy) state <= LD_IDLE;
                end
                default: state <= LD_IDLE;
            endcase
            if (o_addr >= IMAGE_END) begin
                o_done <= 1'b1;
            end
        end
    end

    // write data is payload, held for the whole request
    always_ff @(posedge clk) begin
        if (i_ld_we && o_ld_ready) o_wdata <= i_ld_data;
    end

    // the word source must respect ready, a lost strobe corrupts the image
    a_strobe_when_ready: assert property (
        @(posedge clk) disable iff (i_rst)
        i_ld_we |-> o_ld_ready
    ) else $error("loader strobe while o_ld_ready is low");

endmodule

`default_nettype wire

/* design/readback_verify.sv */
/*
 * Image read-back. Reads every word of the image region once, sums the
 * returned data and compares the sum against the load checksum. The result
 * is registered when the last word is in and held until reset.
 */
`timescale 1ns/1ps
`default_nettype none

module readback_verify #(
    parameter int unsigned IMAGE_BYTES = 32
) (
    input  wire                 clk,
    input  wire                 i_rst,
    input  wire meminit_pkg::phase_t i_phase,
    input  wire                 i_mem_busy,
    input  wire meminit_pkg::word_t i_mem_rdata,
    input  wire meminit_pkg::word_t i_load_checksum,
    output logic                o_rd_en,
    output meminit_pkg::addr_t  o_addr,
    output logic                o_done,
    output logic                o_match
);
    import meminit_pkg::*;

    localparam addr_t IMAGE_END = addr_t'(IMAGE_BYTES);

    typedef enum logic [1:0] {
        RB_REQ,       // raise a read when memory is idle
        RB_WAIT_BUSY, // read requested, waiting for busy
        RB_WAIT_DATA  // read in progress, data on busy fall
    } rb_state_t;

    rb_state_t state;
    word_t     sum;
    logic      active;

    assign active = (i_phase == PH_VERIFY) && !o_done;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= RB_REQ;
            o_rd_en <= 1'b0;
            o_addr  <= '0;
            sum     <= '0;
            o_done  <= 1'b0;
            o_match <= 1'b0;
        end else if (active) begin
            case (state)
                RB_REQ: begin
                    if (!i_mem_busy && (o_addr < IMAGE_END)) begin
                        o_rd_en <= 1'b1;
                        state   <= RB_WAIT_BUSY;
                    end
                end
                RB_WAIT_BUSY: begin
                    if (i_mem_busy) begin
                        o_rd_en <= 1'b0;  // controller has the read
                        state   <= RB_WAIT_DATA;
                    end
                end
                RB_WAIT_DATA: begin
                    if (!i_mem_busy) begin
                        sum    <= sum + i_mem_rdata;  // rdata valid this cycle
                        o_addr <= o_addr + WORD_BYTES;
                        state  <= RB_REQ;
                    end
                end
                default: state <= RB_REQ;
            endcase
            // sum is final once the address has passed the image
            if (o_addr >= IMAGE_END) begin
                o_done  <= 1'b1;
                o_match <= (sum == i_load_checksum);
            end
        end
    end

endmodule

`default_nettype wire

/* design/mem_port_mux.sv */
/*
 * Memory port select. Picks the start-up engine that owns the port for the
 * current phase, and passes the processor bus through only in run.
 * Purely combinational.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_port_mux (
    input  wire meminit_pkg::phase_t i_phase,
    input  wire                 i_zero_wr_en,
    input  wire meminit_pkg::addr_t i_zero_addr,
    input  wire                 i_load_wr_en,
    input  wire meminit_pkg::addr_t i_load_addr,
    input  wire meminit_pkg::word_t i_load_wdata,
    input  wire                 i_verify_rd_en,
    input  wire meminit_pkg::addr_t i_verify_addr,
    input  wire                 i_rd_en,
    input  wire                 i_wr_en,
    input  wire meminit_pkg::addr_t i_addr,
    input  wire meminit_pkg::word_t i_data,
    input  wire meminit_pkg::ctrl_t i_ctrl,
    input  wire                 i_mem_busy,
    output logic                o_mem_rd_en,
    output logic                o_mem_wr_en,
    output meminit_pkg::addr_t  o_mem_addr,
    output meminit_pkg::word_t  o_mem_wdata,
    output meminit_pkg::ctrl_t  o_mem_ctrl,
    output logic                o_busy
);
    import meminit_pkg::*;

    always_comb begin
        // start-up defaults: port quiet, processor held off
        o_mem_rd_en = 1'b0;
        o_mem_wr_en = 1'b0;
        o_mem_addr  = '0;
        o_mem_wdata = '0;
        o_mem_ctrl  = CTRL_FULL;
        o_busy      = 1'b1;
        case (i_phase)
            PH_ZERO: begin
                o_mem_wr_en = i_zero_wr_en;
                o_mem_addr  = i_zero_addr;  // wdata stays zero
            end
            PH_LOAD: begin
                o_mem_wr_en = i_load_wr_en;
                o_mem_addr  = i_load_addr;
                o_mem_wdata = i_load_wdata;
            end
            PH_VERIFY: begin
                o_mem_rd_en = i_verify_rd_en;
                o_mem_addr  = i_verify_addr;
            end
            PH_RUN: begin
                o_mem_rd_en = i_rd_en;
                o_mem_wr_en = i_wr_en;
                o_mem_addr  = i_addr & ADDR_MASK;
                o_mem_wdata = i_data;
                o_mem_ctrl  = i_ctrl;
                o_busy      = i_mem_busy;
            end
            default: ;  // calibration, nothing on the port
        endcase
    end

    // the controller takes one kind of request at a time
    a_rd_wr_excl: assert final (!(o_mem_rd_en && o_mem_wr_en))
        else $error("read and write requested together on memory port");

endmodule

`default_nettype wire

/* design/mem_maint.sv */
/*
 * Memory maintenance top. Runs calibration wait, zero-fill, image load and
 * read-back verify after reset, then hands the memory port to the processor.
 * ZERO_BYTES and IMAGE_BYTES are word multiples, image no larger than zero.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_maint #(
    parameter int unsigned ZERO_BYTES  = 64,
    parameter int unsigned IMAGE_BYTES = 32
) (
    input  wire                 clk,
    input  wire                 i_rst,
    // processor bus
    input  wire                 i_rd_en,
    input  wire                 i_wr_en,
    input  wire meminit_pkg::addr_t i_addr,
    input  wire meminit_pkg::word_t i_data,
    input  wire meminit_pkg::ctrl_t i_ctrl,
    output wire meminit_pkg::word_t o_data,
    output wire                 o_busy,
    // boot image word source
    input  wire                 i_ld_we,
    input  wire meminit_pkg::word_t i_ld_data,
    output wire                 o_ld_ready,
    // memory controller port
    output wire                 o_mem_rd_en,
    output wire                 o_mem_wr_en,
    output wire meminit_pkg::addr_t o_mem_addr,
    output wire meminit_pkg::word_t o_mem_wdata,
    output wire meminit_pkg::ctrl_t o_mem_ctrl,
    input  wire meminit_pkg::word_t i_mem_rdata,
    input  wire                 i_mem_busy,
    input  wire                 i_calib_done,
    // status
    output wire                 o_init_done,
    output wire                 o_checksum_match
);
    import meminit_pkg::*;

    phase_t phase;
    logic   zero_done;
    logic   load_done;
    logic   verify_done;
    logic   zero_wr_en;
    addr_t  zero_addr;
    logic   load_wr_en;
    addr_t  load_addr;
    word_t  load_wdata;
    word_t  load_checksum;
    logic   verify_rd_en;
    addr_t  verify_addr;

    assign o_data = i_mem_rdata;  // read data goes straight back

    init_sequencer i_init_sequencer (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_calib_done  (i_calib_done),
        .i_zero_done   (zero_done),
        .i_load_done   (load_done),
        .i_verify_done (verify_done),
        .o_phase       (phase),
        .o_init_done   (o_init_done)
    );

    zero_fill #(.ZERO_BYTES(ZERO_BYTES)) i_zero_fill (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_phase    (phase),
        .i_mem_busy (i_mem_busy),
        .o_wr_en    (zero_wr_en),
        .o_addr     (zero_addr),
        .o_done     (zero_done)
    );

    image_loader #(.IMAGE_BYTES(IMAGE_BYTES)) i_image_loader (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_phase    (phase),
        .i_mem_busy (i_mem_busy),
        .i_ld_we    (i_ld_we),
        .i_ld_data  (i_ld_data),
        .o_ld_ready (o_ld_ready),
        .o_wr_en    (load_wr_en),
        .o_addr     (load_addr),
        .o_wdata    (load_wdata),
        .o_checksum (load_checksum),
        .o_done     (load_done)
    );

    readback_verify #(.IMAGE_BYTES(IMAGE_BYTES)) i_readback_verify (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_phase         (phase),
        .i_mem_busy      (i_mem_busy),
        .i_mem_rdata     (i_mem_rdata),
        .i_load_checksum (load_checksum),
        .o_rd_en         (verify_rd_en),
        .o_addr          (verify_addr),
        .o_done          (verify_done),
        .o_match         (o_checksum_match)
    );

    mem_port_mux i_mem_port_mux (
        .i_phase        (phase),
        .i_zero_wr_en   (zero_wr_en),
        .i_zero_addr    (zero_addr),
        .i_load_wr_en   (load_wr_en),
        .i_load_addr    (load_addr),
        .i_load_wdata   (load_wdata),
        .i_verify_rd_en (verify_rd_en),
        .i_verify_addr  (verify_addr),
        .i_rd_en        (i_rd_en),
        .i_wr_en        (i_wr_en),
        .i_addr         (i_addr),
        .i_data         (i_data),
        .i_ctrl         (i_ctrl),
        .i_mem_busy     (i_mem_busy),
        .o_mem_rd_en    (o_mem_rd_en),
        .o_mem_wr_en    (o_mem_wr_en),
        .o_mem_addr     (o_mem_addr),
        .o_mem_wdata    (o_mem_wdata),
        .o_mem_ctrl     (o_mem_ctrl),
        .o_busy         (o_busy)
    );

endmodule

`default_nettype wire

/* verification/dram_model.sv */
/*
 * Behavioral DRAM controller for the testbench. 256 bytes held as 64 words,
 * busy for 1 to 4 cycles after each accepted request, byte lane writes, and
 * a switch that flips bit 0 of the word at byte address 8 on reads.
 */
`timescale 1ns/1ps
`default_nettype none

module dram_model (
    input  wire                     clk,
    input  wire                     i_rd_en,
    input  wire                     i_wr_en,
    input  wire meminit_pkg::addr_t i_addr,
    input  wire meminit_pkg::word_t i_wdata,
    input  wire meminit_pkg::ctrl_t i_ctrl,
    input  wire [1:0]               i_busy_len,  // extra busy cycles after the first
    input  wire                     i_corrupt,
    output meminit_pkg::word_t      o_rdata,
    output logic                    o_busy
);
    import meminit_pkg::*;

    word_t      mem [0:63];
    word_t      merged;
    logic [1:0] remaining;
    logic [5:0] index;

    assign index = i_addr[7:2];  // modulo 256, word aligned

    // nonzero fill, every word different
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hc0de_0000 | (i << 2);
        end
        o_rdata   = '0;
        o_busy    = 1'b0;
        remaining = '0;
    end

    // old word with the enabled lanes replaced
    always_comb begin
        merged = mem[index];
        for (int b = 0; b < 4; b++) begin
            if (i_ctrl[b]) merged[8*b +: 8] = i_wdata[8*b +: 8];
        end
    end

    always @(posedge clk) begin
        if (o_busy) begin
            if (remaining == 2'd0) begin
                o_busy <= 1'b0;  // data valid from here on
            end else begin
                remaining <= remaining - 2'd1;
            end
        end else if (i_wr_en) begin
            mem[index] <= merged;
            o_busy     <= 1'b1;
            remaining  <= i_busy_len;
        end else if (i_rd_en) begin
            if (i_corrupt && (index == 6'd2)) begin
                o_rdata <= mem[index] ^ 32'd1;  // byte address 8
            end else begin
                o_rdata <= mem[index];
            end
            o_busy    <= 1'b1;
            remaining <= i_busy_len;
        end
    end

endmodule

`default_nettype wire

/* verification/tb_mem_maint.sv */
/*
 * Testbench for the memory maintenance block. Runs start-up against the DRAM
 * model, reads back the image and zero regions, applies a table of run-mode
 * bus accesses, then repeats start-up with a corrupted read-back.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_maint;
    import meminit_pkg::*;

    localparam int ZERO_BYTES  = 64;
    localparam int IMAGE_BYTES = 32;
    localparam int IMAGE_WORDS = IMAGE_BYTES / 4;
    localparam int ZERO_WORDS  = ZERO_BYTES / 4;
    localparam int RST_CYCLES  = 5;
    localparam int CALIB_WAIT  = 3;
    localparam int OP_MAX      = 8;  // request, accept, up to 4 busy, release
    localparam int N_OPS       = 8;
    localparam int BUS_OPS     = 1 + ZERO_WORDS + N_OPS;
    localparam int STARTUP_MAX = RST_CYCLES + CALIB_WAIT + 8 +
                                 (ZERO_WORDS + 2 * IMAGE_WORDS) * OP_MAX;
    localparam int CYCLE_LIMIT = 2 * (2 * STARTUP_MAX + BUS_OPS * OP_MAX);
    localparam addr_t STRAY_ADDR = 32'h0000_003c;  // zero region, past the image

    typedef struct packed {
        logic  is_write;
        addr_t op_addr;
        word_t value;  // write data, or expected read data
        ctrl_t lanes;
    } bus_op_t;

    logic  clk = 1'b0;
    logic  rst;
    logic  rd_en;
    logic  wr_en;
    addr_t addr;
    word_t data;
    ctrl_t ctrl;
    word_t cpu_data;
    logic  cpu_busy;
    logic  ld_we = 1'b0;
    word_t ld_data = '0;
    logic  ld_ready;
    logic  mem_rd_en;
    logic  mem_wr_en;
    addr_t mem_addr;
    word_t mem_wdata;
    ctrl_t mem_ctrl;
    word_t mem_rdata;
    logic  mem_busy;
    logic  calib_done;
    logic  init_done;
    logic  checksum_match;
    logic  [1:0] busy_len = 2'd0;
    logic  corrupt;

    logic  [31:0] lfsr;
    word_t ld_words [0:IMAGE_WORDS-1];  // words as streamed, in address order
    int    ld_count = 0;
    int    cycles = 0;
    bus_op_t ops [0:N_OPS-1];

    mem_maint #(
        .ZERO_BYTES  (ZERO_BYTES),
        .IMAGE_BYTES (IMAGE_BYTES)
    ) i_mem_maint (
        .clk (clk), .i_rst (rst),
        .i_rd_en (rd_en), .i_wr_en (wr_en), .i_addr (addr), .i_data (data),
        .i_ctrl (ctrl), .o_data (cpu_data), .o_busy (cpu_busy),
        .i_ld_we (ld_we), .i_ld_data (ld_data), .o_ld_ready (ld_ready),
        .o_mem_rd_en (mem_rd_en), .o_mem_wr_en (mem_wr_en), .o_mem_addr (mem_addr),
        .o_mem_wdata (mem_wdata), .o_mem_ctrl (mem_ctrl), .i_mem_rdata (mem_rdata),
        .i_mem_busy (mem_busy), .i_calib_done (calib_done),
        .o_init_done (init_done), .o_checksum_match (checksum_match)
    );

    dram_model i_dram_model (
        .clk (clk), .i_rd_en (mem_rd_en), .i_wr_en (mem_wr_en), .i_addr (mem_addr),
        .i_wdata (mem_wdata), .i_ctrl (mem_ctrl), .i_busy_len (busy_len),
        .i_corrupt (corrupt), .o_rdata (mem_rdata), .o_busy (mem_busy)
    );

    always #50 clk = ~clk;

    function automatic logic step_lfsr();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) lfsr = lfsr ^ 32'h8020_0003;
        return out;
    endfunction

    // msb first, one lfsr step per bit
    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], step_lfsr()};
        end
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // one processor access, called just after a rising edge
    task automatic bus_access(input logic is_write, input addr_t a, input word_t d,
                              input ctrl_t c, output word_t rdata);
        rd_en = !is_write;
        wr_en = is_write;
        addr  = a;
        data  = d;
        ctrl  = c;
        #1;
        check_value("masked address", a & 32'h03ff_ffff, mem_addr);
        check_value("byte controls", word_t'(c), word_t'(mem_ctrl));
        do begin
            @(posedge clk);
            #1;
        end while (!cpu_busy);
        rd_en = 1'b0;  // request taken
        wr_en = 1'b0;
        while (cpu_busy) begin
            @(posedge clk);
            #1;
        end
        rdata = cpu_data;
    endtask

    // reset, calibrate and wait for init done, with a stray write held all along
    task automatic run_startup(input logic corrupt_rd);
        corrupt    = corrupt_rd;
        rst        = 1'b1;
        calib_done = 1'b0;
        wr_en      = 1'b1;
        addr       = STRAY_ADDR;
        data       = 32'hdead_beef;
        ctrl       = 4'hf;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        check_value("outputs after reset", 32'h01, word_t'({mem_rd_en, mem_wr_en,
                    ld_ready, init_done, checksum_match, cpu_busy}));
        rst = 1'b0;
        repeat (CALIB_WAIT) @(posedge clk);
        #1 calib_done = 1'b1;
        while (!init_done) begin
            check_value("busy during start-up", 32'd1, word_t'(cpu_busy));
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;
    endtask

    // memory busy length and loader words
    always @(posedge clk) begin : drive_random
        word_t rnd;
        #1;
        rnd      = take_bits(2);
        busy_len = rnd[1:0];
        if (rst) begin
            ld_count = 0;
            ld_we    = 1'b0;
        end else if (ld_ready && (ld_count < IMAGE_WORDS)) begin
            ld_data            = take_bits(32);
            ld_words[ld_count] = ld_data;
            ld_count++;
            ld_we = 1'b1;
        end else begin
            ld_we = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) fail_run("timeout, start-up or a bus access never finished");
    end

    initial begin : main
        word_t rdata;
        lfsr       = 32'h9394;
        rst        = 1'b1;
        calib_done = 1'b0;
        rd_en      = 1'b0;
        wr_en      = 1'b0;
        addr       = '0;
        data       = '0;
        ctrl       = 4'hf;
        corrupt    = 1'b0;

        // masked addresses land at 0x80 and 0x94
        ops[0] = '{1'b1, 32'h0400_0080, 32'h1122_3344, 4'hf};
        ops[1] = '{1'b0, 32'h0000_0080, 32'h1122_3344, 4'hf};
        ops[2] = '{1'b1, 32'hfc00_0080, 32'haabb_ccdd, 4'h5};
        ops[3] = '{1'b0, 32'h0800_0080, 32'h11bb_33dd, 4'hf};  // lanes 0 and 2 new
        ops[4] = '{1'b1, 32'h8000_0094, 32'hcafe_f00d, 4'hf};
        ops[5] = '{1'b1, 32'h0000_0094, 32'h1234_5678, 4'hc};
        ops[6] = '{1'b1, 32'h4200_0094, 32'h0000_00aa, 4'h1};
        ops[7] = '{1'b0, 32'hffff_ff94, 32'h1234_f0aa, 4'hf};

        run_startup(1'b0);
        check_value("checksum match after clean start-up", 32'd1, word_t'(checksum_match));
        bus_access(1'b0, STRAY_ADDR, '0, 4'hf, rdata);
        check_value("write during start-up ignored", 32'd0, rdata);
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            bus_access(1'b0, addr_t'(i * 4), '0, 4'hf, rdata);
            check_value($sformatf("image word %0d", i), ld_words[i], rdata);
        end
        for (int i = IMAGE_WORDS; i < ZERO_WORDS; i++) begin
            bus_access(1'b0, addr_t'(i * 4), '0, 4'hf, rdata);
            check_value($sformatf("zero word %0d", i), 32'd0, rdata);
        end
        for (int i = 0; i < N_OPS; i++) begin
            bus_access(ops[i].is_write, ops[i].op_addr, ops[i].value, ops[i].lanes, rdata);
            if (!ops[i].is_write) begin
                check_value($sformatf("table op %0d", i), ops[i].value, rdata);
            end
        end

        run_startup(1'b1);  // read-back of byte address 8 corrupted
        check_value("checksum match with corrupted read", 32'd0, word_t'(checksum_match));

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/meminit_pkg.sv
design/init_sequencer.sv
design/zero_fill.sv
design/image_loader.sv
design/readback_verify.sv
design/mem_port_mux.sv
design/mem_maint.sv
verification/dram_model.sv
verification/tb_mem_maint.sv

/* Makefile */
TOP = tb_mem_maint

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
